/* common/laser_settings.svh */
`ifndef LASER_SETTINGS_SVH
`define LASER_SETTINGS_SVH

// grid is LASER_GRID x LASER_GRID positions
`define LASER_GRID       16
`define LASER_COORD_W    4

`define LASER_NUM_POINTS 40
`define LASER_IDX_W      6

// covered when dx*dx + dy*dy <= radius squared
`define LASER_RADIUS_SQ  16
`define LASER_DIST_W     9

`endif

/* common/laser_geom_pkg.sv */
`include "laser_settings.svh"

package laser_geom_pkg;

	typedef logic [`LASER_COORD_W-1:0] coord_t;

	typedef struct packed
	{
		coord_t x;
		coord_t y;
	} point_t;

	// one bit per loaded point
	typedef logic [`LASER_NUM_POINTS-1:0] cover_mask_t;

	typedef logic [`LASER_IDX_W-1:0] count_t;

	typedef logic [`LASER_IDX_W-1:0] idx_t;

endpackage

/* common/laser_ctrl_pkg.sv */
package laser_ctrl_pkg;

	typedef enum logic [2:0]
	{
		S_LOAD,
		S_SEARCH1_ACC,
		S_SEARCH1_CMP,
		S_SEARCH2_ACC,
		S_SEARCH2_CMP,
		S_RESULT
	} ctrl_state_e;

	typedef enum logic
	{
		CIRCLE_FIRST,
		CIRCLE_SECOND
	} circle_e;

	typedef struct packed
	{
		laser_geom_pkg::point_t c1;
		laser_geom_pkg::point_t c2;
	} result_t;

endpackage

/* hw/point_store.sv */
`timescale 1ns/1ps
`include "laser_settings.svh"

module point_store
(
	input  logic                   CLK,
	input  logic                   wr_en,
	input  laser_geom_pkg::idx_t   wr_idx,
	input  laser_geom_pkg::point_t wr_point,
	input  laser_geom_pkg::idx_t   rd_idx,
	output laser_geom_pkg::point_t rd_point
);

	// target points of the current frame
	laser_geom_pkg::point_t mem [`LASER_NUM_POINTS];

	always_ff @(posedge CLK)
	begin
		if (wr_en)
			mem[wr_idx] <= wr_point;
	end

	assign rd_point = mem[rd_idx];

endmodule

/* hw/search/cover_calc.sv */
`timescale 1ns/1ps
`include "laser_settings.svh"

module cover_calc
(
	input  logic                        CLK,
	input  logic                        RST,
	input  laser_geom_pkg::point_t      center,
	input  laser_geom_pkg::point_t      point,
	input  laser_geom_pkg::idx_t        point_idx,
	input  logic                        acc_en,
	input  logic                        acc_clear,
	input  laser_ctrl_pkg::circle_e     circle,
	input  laser_geom_pkg::cover_mask_t c1_mask,
	output laser_geom_pkg::count_t      hit_count,
	output laser_geom_pkg::cover_mask_t hit_mask
);

	laser_geom_pkg::coord_t        dx;
	laser_geom_pkg::coord_t        dy;
	logic [2*`LASER_COORD_W-1:0]   sq_x;
	logic [2*`LASER_COORD_W-1:0]   sq_y;
	logic [`LASER_DIST_W-1:0]      dist_sq;
	logic                          hit;
	logic                          counted;

	assign dx = (center.x >= point.x) ? center.x - point.x : point.x - center.x;
	assign dy = (center.y >= point.y) ? center.y - point.y : point.y - center.y;

	assign sq_x    = dx * dx;
	assign sq_y    = dy * dy;
	assign dist_sq = sq_x + sq_y;
	assign hit     = (dist_sq <= `LASER_RADIUS_SQ);

	// second circle only scores points the first one missed
	assign counted = hit && !((circle == laser_ctrl_pkg::CIRCLE_SECOND) && c1_mask[point_idx]);

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			hit_count <= '0;
			hit_mask  <= '0;
		end
		else if (acc_clear)
		begin
			hit_count <= '0;
			hit_mask  <= '0;
		end
		else if (acc_en)
		begin
			if (hit)
				hit_mask[point_idx] <= 1'b1;
			if (counted)
				hit_count <= hit_count + 1'b1;
		end
	end

endmodule

/* hw/search/best_tracker.sv */
`timescale 1ns/1ps

module best_tracker
(
	input  logic                        CLK,
	input  logic                        RST,
	input  logic                        frame_start,
	input  logic                        cmp_en,
	input  laser_ctrl_pkg::circle_e     circle,
	input  laser_geom_pkg::point_t      center,
	input  laser_geom_pkg::count_t      hit_count,
	input  laser_geom_pkg::cover_mask_t hit_mask,
	output laser_geom_pkg::cover_mask_t c1_mask,
	output laser_ctrl_pkg::result_t     result
);

	laser_geom_pkg::count_t best1;
	laser_geom_pkg::count_t best2;

	// >= so that the last scanned position wins a tie
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			best1   <= '0;
			best2   <= '0;
			c1_mask <= '0;
			result  <= '0;
		end
		else if (frame_start)
		begin
			best1   <= '0;
			best2   <= '0;
			c1_mask <= '0;
			result  <= '0;
		end
		else if (cmp_en)
		begin
			if (circle == laser_ctrl_pkg::CIRCLE_FIRST)
			begin
				if (hit_count >= best1)
				begin
					best1     <= hit_count;
					result.c1 <= center;
					c1_mask   <= hit_mask;
				end
			end
			else if (hit_count >= best2)
			begin
				best2     <= hit_count;
				result.c2 <= center;
			end
		end
	end

endmodule

/* hw/laser_ctrl.sv */
`timescale 1ns/1ps
`include "laser_settings.svh"

module laser_ctrl
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic                    in_valid,
	output logic                    in_ready,
	output logic                    out_valid,
	input  logic                    out_ready,
	output logic                    wr_en,
	output laser_geom_pkg::idx_t    wr_idx,
	output laser_geom_pkg::idx_t    rd_idx,
	output laser_geom_pkg::point_t  center,
	output logic                    acc_en,
	output logic                    acc_clear,
	output logic                    cmp_en,
	output laser_ctrl_pkg::circle_e circle,
	output logic                    frame_start
);

	laser_ctrl_pkg::ctrl_state_e state;
	laser_ctrl_pkg::ctrl_state_e next_state;
	laser_geom_pkg::idx_t        idx;
	logic                        last_idx;
	logic                        last_center;

	assign last_idx = (idx == laser_geom_pkg::idx_t'(`LASER_NUM_POINTS - 1));
	assign last_center = (center.x == laser_geom_pkg::coord_t'(`LASER_GRID - 1)) &&
		(center.y == laser_geom_pkg::coord_t'(`LASER_GRID - 1));

	assign in_ready  = (state == laser_ctrl_pkg::S_LOAD);
	assign out_valid = (state == laser_ctrl_pkg::S_RESULT);
	assign wr_en     = in_valid && in_ready;
	assign wr_idx    = idx;
	assign rd_idx    = idx;
	assign acc_en    = (state == laser_ctrl_pkg::S_SEARCH1_ACC) ||
		(state == laser_ctrl_pkg::S_SEARCH2_ACC);
	assign acc_clear = (state == laser_ctrl_pkg::S_SEARCH1_CMP) ||
		(state == laser_ctrl_pkg::S_SEARCH2_CMP);
	assign cmp_en    = acc_clear;
	assign circle    = ((state == laser_ctrl_pkg::S_SEARCH2_ACC) ||
		(state == laser_ctrl_pkg::S_SEARCH2_CMP)) ?
		laser_ctrl_pkg::CIRCLE_SECOND : laser_ctrl_pkg::CIRCLE_FIRST;
	// first accepted point of a frame
	assign frame_start = wr_en && (idx == '0);

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			state <= laser_ctrl_pkg::S_LOAD;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			laser_ctrl_pkg::S_LOAD:
				if (wr_en && last_idx)
					next_state = laser_ctrl_pkg::S_SEARCH1_ACC;
			laser_ctrl_pkg::S_SEARCH1_ACC:
				if (last_idx)
					next_state = laser_ctrl_pkg::S_SEARCH1_CMP;
			laser_ctrl_pkg::S_SEARCH1_CMP:
				next_state = last_center ? laser_ctrl_pkg::S_SEARCH2_ACC :
					laser_ctrl_pkg::S_SEARCH1_ACC;
			laser_ctrl_pkg::S_SEARCH2_ACC:
				if (last_idx)
					next_state = laser_ctrl_pkg::S_SEARCH2_CMP;
			laser_ctrl_pkg::S_SEARCH2_CMP:
				next_state = last_center ? laser_ctrl_pkg::S_RESULT :
					laser_ctrl_pkg::S_SEARCH2_ACC;
			laser_ctrl_pkg::S_RESULT:
				if (out_ready)
					next_state = laser_ctrl_pkg::S_LOAD;
			default:
				next_state = laser_ctrl_pkg::S_LOAD;
		endcase
	end

	// shared by loading and accumulation
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			idx <= '0;
		else if (wr_en || acc_en)
		begin
			if (last_idx)
				idx <= '0;
			else
				idx <= idx + 1'b1;
		end
	end

	// x first, carry into y, wraps to 0,0 after the last candidate
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			center <= '0;
		else if (in_ready)
			center <= '0;
		else if (cmp_en)
		begin
			center.x <= center.x + 1'b1;
			if (center.x == laser_geom_pkg::coord_t'(`LASER_GRID - 1))
				center.y <= center.y + 1'b1;
		end
	end

endmodule

/* hw/laser_top.sv */
`timescale 1ns/1ps

module laser_top
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  laser_geom_pkg::point_t  in_point,
	output logic                    out_valid,
	input  logic                    out_ready,
	output laser_ctrl_pkg::result_t out_result
);

	logic                        wr_en;
	laser_geom_pkg::idx_t        wr_idx;
	laser_geom_pkg::idx_t        rd_idx;
	laser_geom_pkg::point_t      rd_point;
	laser_geom_pkg::point_t      center;
	logic                        acc_en;
	logic                        acc_clear;
	logic                        cmp_en;
	laser_ctrl_pkg::circle_e     circle;
	logic                        frame_start;
	laser_geom_pkg::cover_mask_t c1_mask;
	laser_geom_pkg::count_t      hit_count;
	laser_geom_pkg::cover_mask_t hit_mask;

	laser_ctrl i_ctrl
	(
		.CLK         (CLK),
		.RST         (RST),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.wr_en       (wr_en),
		.wr_idx      (wr_idx),
		.rd_idx      (rd_idx),
		.center      (center),
		.acc_en      (acc_en),
		.acc_clear   (acc_clear),
		.cmp_en      (cmp_en),
		.circle      (circle),
		.frame_start (frame_start)
	);

	point_store i_store
	(
		.CLK      (CLK),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_point (in_point),
		.rd_idx   (rd_idx),
		.rd_point (rd_point)
	);

	cover_calc i_cover
	(
		.CLK       (CLK),
		.RST       (RST),
		.center    (center),
		.point     (rd_point),
		.point_idx (rd_idx),
		.acc_en    (acc_en),
		.acc_clear (acc_clear),
		.circle    (circle),
		.c1_mask   (c1_mask),
		.hit_count (hit_count),
		.hit_mask  (hit_mask)
	);

	best_tracker i_best
	(
		.CLK         (CLK),
		.RST         (RST),
		.frame_start (frame_start),
		.cmp_en      (cmp_en),
		.circle      (circle),
		.center      (center),
		.hit_count   (hit_count),
		.hit_mask    (hit_mask),
		.c1_mask     (c1_mask),
		.result      (out_result)
	);

endmodule

/* testbench/tb_laser_checks.sv */
`timescale 1ns/1ps
`include "laser_settings.svh"

module tb_laser_checks
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic                    in_valid,
	input  logic                    in_ready,
	input  laser_geom_pkg::point_t  in_point,
	input  logic                    out_valid,
	input  logic                    out_ready,
	input  laser_ctrl_pkg::result_t out_result,
	output int                      passes,
	output int                      errors
);

	localparam int SEARCH_CYCLES = 2 * `LASER_GRID * `LASER_GRID * (`LASER_NUM_POINTS + 1);

	laser_geom_pkg::point_t  pts [`LASER_NUM_POINTS];
	laser_ctrl_pkg::result_t expected;
	int                      n_loaded;
	int                      wait_cycles;
	logic                    started;
	logic                    busy;
	int                      value_errors = 0;
	int                      idle_errors = 0;
	int                      busy_errors = 0;
	int                      ready_errors = 0;
	int                      hold_errors = 0;
	int                      latency_errors = 0;

	initial passes = 0;

	assign errors = value_errors + idle_errors + busy_errors + ready_errors + hold_errors +
		latency_errors;

	function automatic logic in_circle(laser_geom_pkg::point_t c, laser_geom_pkg::point_t pt);
		int dx;
		int dy;
		dx = int'(c.x) - int'(pt.x);
		dy = int'(c.y) - int'(pt.y);
		return (dx * dx + dy * dy) <= `LASER_RADIUS_SQ;
	endfunction

	// points under c, leaving out those under c1 when skip_c1 is set
	function automatic int count_cover(laser_geom_pkg::point_t c, logic skip_c1,
		laser_geom_pkg::point_t c1);
		int n;
		n = 0;
		for (int i = 0; i < `LASER_NUM_POINTS; i++)
			if (in_circle(c, pts[i]) && !(skip_c1 && in_circle(c1, pts[i])))
				n++;
		return n;
	endfunction

	// y outer, x inner, a tie goes to the later position
	function automatic laser_ctrl_pkg::result_t place_lasers();
		laser_ctrl_pkg::result_t r;
		laser_geom_pkg::point_t  c;
		int                      best;
		int                      n;
		r = '0;
		for (int pass = 0; pass < 2; pass++)
		begin
			best = 0;
			for (int y = 0; y < `LASER_GRID; y++)
				for (int x = 0; x < `LASER_GRID; x++)
				begin
					c.x = laser_geom_pkg::coord_t'(x);
					c.y = laser_geom_pkg::coord_t'(y);
					n = count_cover(c, pass == 1, r.c1);
					if (n >= best)
					begin
						best = n;
						if (pass == 0)
							r.c1 = c;
						else
							r.c2 = c;
					end
				end
		end
		return r;
	endfunction

	always @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			n_loaded    <= 0;
			wait_cycles <= 0;
			started     <= 1'b0;
			busy        <= 1'b0;
		end
		else
		begin
			if (in_valid && in_ready)
			begin
				pts[n_loaded] <= in_point;
				started       <= 1'b1;
				n_loaded      <= (n_loaded == `LASER_NUM_POINTS - 1) ? 0 : n_loaded + 1;
				if (n_loaded == `LASER_NUM_POINTS - 1)
				begin
					busy        <= 1'b1;
					wait_cycles <= 0;
				end
			end
			else if (busy && !out_valid)
				wait_cycles <= wait_cycles + 1;
			if (out_valid && out_ready)
			begin
				busy <= 1'b0;
				expected = place_lasers();
				assert (out_result.c1 == expected.c1)
					passes++;
				else
				begin
					value_errors++;
					$display("Error at time %0t: c1 is (%0d,%0d), expected (%0d,%0d)", $time,
						out_result.c1.x, out_result.c1.y, expected.c1.x, expected.c1.y);
				end
				assert (out_result.c2 == expected.c2)
					passes++;
				else
				begin
					value_errors++;
					$display("Error at time %0t: c2 is (%0d,%0d), expected (%0d,%0d)", $time,
						out_result.c2.x, out_result.c2.y, expected.c2.x, expected.c2.y);
				end
			end
		end
	end

	assert property (@(posedge CLK) disable iff (RST) !started |-> (in_ready && !out_valid))
	else
	begin
		idle_errors++;
		$display("Error at time %0t: in_ready low or out_valid high before any point", $time);
	end

	assert property (@(posedge CLK) disable iff (RST) busy |-> !in_ready)
	else
	begin
		busy_errors++;
		$display("Error at time %0t: in_ready high while a frame is in search", $time);
	end

	assert property (@(posedge CLK) disable iff (RST)
		(out_valid && out_ready) |=> (in_ready && !out_valid))
	else
	begin
		ready_errors++;
		$display("Error at time %0t: no return to loading after the result transfer", $time);
	end

	// back-pressure holds the result
	assert property (@(posedge CLK) disable iff (RST)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
	else
	begin
		hold_errors++;
		$display("Error at time %0t: result changed or dropped under back-pressure", $time);
	end

	assert property (@(posedge CLK) disable iff (RST)
		$rose(out_valid) |-> (wait_cycles == SEARCH_CYCLES))
	else
	begin
		latency_errors++;
		$display("Error at time %0t: result after %0d cycles, expected %0d", $time,
			wait_cycles, SEARCH_CYCLES);
	end

endmodule

/* testbench/tb_laser.sv */
`timescale 1ns/1ps
`include "laser_settings.svh"

module tb_laser;

	localparam int SEARCH_CYCLES = 2 * `LASER_GRID * `LASER_GRID * (`LASER_NUM_POINTS + 1);
	// search plus a load with random gaps and the result hand-off
	localparam int FRAME_CYCLES = SEARCH_CYCLES + 108;
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 6700;
	localparam int RESULT_CHECKS = 6;

	logic                    CLK;
	logic                    RST;
	logic                    in_valid;
	logic                    in_ready;
	laser_geom_pkg::point_t  in_point;
	logic                    out_valid;
	logic                    out_ready;
	laser_ctrl_pkg::result_t out_result;
	int                      passes;
	int                      errors;
	int                      errors_before;
	int                      seed;
	int                      cycles;
	laser_geom_pkg::point_t  frame [`LASER_NUM_POINTS];

	laser_top i_dut
	(
		.CLK        (CLK),
		.RST        (RST),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_point   (in_point),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	tb_laser_checks i_checks
	(
		.CLK        (CLK),
		.RST        (RST),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_point   (in_point),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result),
		.passes     (passes),
		.errors     (errors)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

	// 25 points in a 5x5 block, the rest in a 4x4 block
	function automatic laser_geom_pkg::point_t cluster_point(input int i);
		laser_geom_pkg::point_t p;
		if (i < 25)
		begin
			p.x = laser_geom_pkg::coord_t'(2 + i % 5);
			p.y = laser_geom_pkg::coord_t'(2 + i / 5);
		end
		else
		begin
			p.x = laser_geom_pkg::coord_t'(10 + (i - 25) % 4);
			p.y = laser_geom_pkg::coord_t'(10 + (i - 25) / 4);
		end
		return p;
	endfunction

	task automatic send_point(input laser_geom_pkg::point_t p);
		logic accepted;
		begin
			accepted = 1'b0;
			while (!accepted)
			begin
				@(negedge CLK);
				in_point = p;
				in_valid = (($random(seed) & 3) != 0);
				accepted = in_valid && in_ready;
			end
		end
	endtask

	task automatic take_result();
		logic taken;
		int   stall;
		begin
			taken = 1'b0;
			stall = 3;
			while (!taken)
			begin
				@(negedge CLK);
				// a few cycles of back-pressure once the result shows up
				if (out_valid && stall > 0)
				begin
					out_ready = 1'b0;
					stall--;
				end
				else
					out_ready = (($random(seed) & 1) != 0);
				taken = out_ready && out_valid;
			end
			@(negedge CLK);
			out_ready = 1'b0;
		end
	endtask

	task automatic run_frame(input string name);
		begin
			errors_before = errors;
			for (int i = 0; i < `LASER_NUM_POINTS; i++)
				send_point(frame[i]);
			@(negedge CLK);
			in_valid = 1'b0;
			take_result();
			$display("test %s done, %0d errors", name, errors - errors_before);
		end
	endtask

	initial
	begin
		seed      = 32'h0ebb4018;
		RST       = 1'b1;
		in_valid  = 1'b0;
		in_point  = '0;
		out_ready = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;
		errors_before = errors;
		repeat (4) @(negedge CLK);
		$display("test reset_state done, %0d errors", errors - errors_before);

		for (int i = 0; i < `LASER_NUM_POINTS; i++)
			frame[i] = cluster_point(i);
		run_frame("cluster");

		for (int i = 0; i < `LASER_NUM_POINTS; i++)
		begin
			frame[i].x = laser_geom_pkg::coord_t'($random(seed));
			frame[i].y = laser_geom_pkg::coord_t'($random(seed));
		end
		run_frame("random");

		// every position tied, so the scan order picks the centers
		for (int i = 0; i < `LASER_NUM_POINTS; i++)
			frame[i] = '{x: 4'd9, y: 4'd6};
		run_frame("single_spot");

		$display("passes %0d, errors %0d", passes, errors);
		if (passes != RESULT_CHECKS)
			$display("Only %0d of %0d result checks ran", passes, RESULT_CHECKS);
		if (errors == 0 && passes == RESULT_CHECKS)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+common
common/laser_geom_pkg.sv
common/laser_ctrl_pkg.sv
hw/point_store.sv
hw/search/cover_calc.sv
hw/search/best_tracker.sv
hw/laser_ctrl.sv
hw/laser_top.sv
testbench/tb_laser_checks.sv
testbench/tb_laser.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_laser
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; \
	else echo "PASS"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
